// ==== logic/dot_types_pkg.sv ====
package dot_types_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // One vector element and the running sum
  localparam int DATA_W = 16;

  // Vector length and element count
  localparam int LEN_W = 8;

  //////////////////////////////
  // Types
  //////////////////////////////

  // Element and truncated sum
  typedef logic [DATA_W-1:0] data_word_t;

  // Full multiplier result before truncation
  typedef logic [2*DATA_W-1:0] product_t;

  // Legal range 1 to 255
  typedef logic [LEN_W-1:0] length_t;

endpackage

// ==== logic/dot_ctrl_pkg.sv ====
package dot_ctrl_pkg;

  //////////////////////////////
  // Sequencing states
  //////////////////////////////

  // Intake side
  // IDLE waits for START, COLLECT pairs elements, DRAIN waits for the result
  typedef enum logic [1:0] {
    IDLE,
    COLLECT,
    DRAIN
  } intake_state_t;

  // Result side
  typedef enum logic {
    WAIT_SUM,
    REPORT
  } result_state_t;

endpackage

// ==== logic/element_if.sv ====
interface element_if;
  import dot_types_pkg::*;

  // Pair strobe, one cycle per element pair
  logic       valid;
  // Element 0 of the vector
  logic       first;
  // Element LENGTH-1 of the vector
  logic       last;
  // Operands
  data_word_t a;
  data_word_t b;

  // Intake side
  modport source (
    output valid,
    output first,
    output last,
    output a,
    output b
  );

  // Accumulator side, always accepts
  modport sink (
    input valid,
    input first,
    input last,
    input a,
    input b
  );

endinterface

// ==== logic/vector_intake.sv ====
module vector_intake (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  dot_types_pkg::length_t    LENGTH_IN,
  input  logic                      DATA_A_IN_ENABLE,
  input  logic                      DATA_B_IN_ENABLE,
  input  dot_types_pkg::data_word_t DATA_A_IN,
  input  dot_types_pkg::data_word_t DATA_B_IN,
  input  logic                      done,
  output logic                      READY,
  element_if.source                 elem
);
  import dot_types_pkg::*;
  import dot_ctrl_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  intake_state_t state;
  // Set on the first clock after reset
  logic          live;
  length_t       len_q;
  length_t       count;

  // Holding registers for the early stream
  logic          a_held;
  logic          b_held;
  data_word_t    a_hold;
  data_word_t    b_hold;

  logic          accept;
  logic          a_en;
  logic          b_en;
  logic          pair;
  logic          last_pair;

  //////////////////////////////
  // Decode
  //////////////////////////////

  // Enables only count while collecting
  assign a_en = (state == COLLECT) && DATA_A_IN_ENABLE;
  assign b_en = (state == COLLECT) && DATA_B_IN_ENABLE;

  // Pair complete at the later of the two enables
  assign pair      = (a_held || a_en) && (b_held || b_en);
  assign last_pair = pair && (count == len_q - length_t'(1));

  // Ready again in the cycle the result is reported
  assign READY  = ((state == IDLE) && live) || ((state == DRAIN) && done);
  assign accept = START && READY;

  // Intake FSM and element counter
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      live  <= 1'b0;
      len_q <= '0;
      count <= '0;
    end else begin
      live <= 1'b1;
      if (accept) begin
        state <= COLLECT;
        len_q <= LENGTH_IN;
        count <= '0;
      end else begin
        case (state)
          COLLECT: begin
            if (pair) begin
              count <= count + length_t'(1);
            end
            // Last pair out, wait for the sum
            if (last_pair) begin
              state <= DRAIN;
            end
          end
          DRAIN: begin
            if (done) begin
              state <= IDLE;
            end
          end
          IDLE: begin
            state <= IDLE;
          end
          default: begin
            state <= IDLE;
          end
        endcase
      end
    end
  end

  // Pair tags and held flags
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      elem.valid <= 1'b0;
      elem.first <= 1'b0;
      elem.last  <= 1'b0;
      a_held     <= 1'b0;
      b_held     <= 1'b0;
    end else begin
      elem.valid <= pair;
      elem.first <= pair && (count == '0);
      elem.last  <= last_pair;
      // An element arriving with the pair it completes stays held
      a_held <= pair ? (a_held && a_en) : (a_held || a_en);
      b_held <= pair ? (b_held && b_en) : (b_held || b_en);
    end
  end

  // Operand data
  always_ff @(posedge CLK) begin
    if (pair) begin
      elem.a <= a_held ? a_hold : DATA_A_IN;
      elem.b <= b_held ? b_hold : DATA_B_IN;
    end
    if (a_en && (a_held || !pair)) begin
      a_hold <= DATA_A_IN;
    end
    if (b_en && (b_held || !pair)) begin
      b_hold <= DATA_B_IN;
    end
  end

  //////////////////////////////
  // Protocol checks
  //////////////////////////////

  // Zero length is not supported
  assert property (@(posedge CLK) disable iff (RST) accept |-> (LENGTH_IN != '0))
    else $error("vector_intake: START with zero length");

  // A stream one element ahead may not advance again alone
  assert property (@(posedge CLK) disable iff (RST)
    (a_held && DATA_A_IN_ENABLE) |-> DATA_B_IN_ENABLE)
    else $error("vector_intake: A stream two elements ahead");

  assert property (@(posedge CLK) disable iff (RST)
    (b_held && DATA_B_IN_ENABLE) |-> DATA_A_IN_ENABLE)
    else $error("vector_intake: B stream two elements ahead");

  // Elements only between START and the last pair
  assert property (@(posedge CLK) disable iff (RST)
    (state != COLLECT) |-> !(DATA_A_IN_ENABLE || DATA_B_IN_ENABLE))
    else $error("vector_intake: element enable outside a vector");

endmodule

// ==== logic/dot_accumulator.sv ====
module dot_accumulator #(
  parameter int MULT_STAGES = 2
) (
  input  logic                      CLK,
  input  logic                      RST,
  element_if.sink                   elem,
  output logic                      sum_valid,
  output dot_types_pkg::data_word_t sum,
  output logic                      sum_overflow
);
  import dot_types_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Multiplier pipeline, payload and tags
  product_t               pipe_prod [MULT_STAGES];
  logic [MULT_STAGES-1:0] pipe_valid;
  logic [MULT_STAGES-1:0] pipe_first;
  logic [MULT_STAGES-1:0] pipe_last;

  // Pipeline tail
  product_t               tail_prod;
  data_word_t             tail_lo;
  logic                   tail_wide;
  logic                   tail_valid;
  logic                   tail_first;
  logic                   tail_last;

  // Running sum with carry out
  data_word_t             acc;
  logic [DATA_W:0]        add_res;
  logic                   ovf;
  logic                   last_added;

  // Vector open at the tail, for the tag check
  logic                   open_q;

  //////////////////////////////
  // Multiply
  //////////////////////////////

  // Tags shift alongside the products
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      pipe_valid <= '0;
      pipe_first <= '0;
      pipe_last  <= '0;
    end else begin
      pipe_valid[0] <= elem.valid;
      pipe_first[0] <= elem.first;
      pipe_last[0]  <= elem.last;
      for (int i = 1; i < MULT_STAGES; i++) begin
        pipe_valid[i] <= pipe_valid[i-1];
        pipe_first[i] <= pipe_first[i-1];
        pipe_last[i]  <= pipe_last[i-1];
      end
    end
  end

  // Full-width product
  always_ff @(posedge CLK) begin
    pipe_prod[0] <= product_t'(elem.a) * product_t'(elem.b);
    for (int i = 1; i < MULT_STAGES; i++) begin
      pipe_prod[i] <= pipe_prod[i-1];
    end
  end

  assign tail_prod  = pipe_prod[MULT_STAGES-1];
  assign tail_valid = pipe_valid[MULT_STAGES-1];
  assign tail_first = pipe_first[MULT_STAGES-1];
  assign tail_last  = pipe_last[MULT_STAGES-1];

  //////////////////////////////
  // Accumulate
  //////////////////////////////

  // Truncated product and lost upper half
  assign tail_lo   = tail_prod[DATA_W-1:0];
  assign tail_wide = |tail_prod[2*DATA_W-1:DATA_W];
  assign add_res   = {1'b0, acc} + {1'b0, tail_lo};

  // Sum restarts on the first product
  always_ff @(posedge CLK) begin
    if (tail_valid) begin
      acc <= tail_first ? tail_lo : add_res[DATA_W-1:0];
    end
  end

  // Sticky overflow and the done strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ovf        <= 1'b0;
      last_added <= 1'b0;
      sum_valid  <= 1'b0;
      open_q     <= 1'b0;
    end else begin
      last_added <= tail_valid && tail_last;
      // One cycle after the last add
      sum_valid  <= last_added;
      if (tail_valid) begin
        ovf    <= tail_first ? tail_wide : (ovf || tail_wide || add_res[DATA_W]);
        open_q <= !tail_last;
      end
    end
  end

  assign sum          = acc;
  assign sum_overflow = ovf;

  // Each vector closes before the next one opens
  assert property (@(posedge CLK) disable iff (RST)
    (tail_valid && tail_first) |-> !open_q)
    else $error("dot_accumulator: first element without a preceding last");

endmodule

// ==== logic/result_stage.sv ====
module result_stage (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      sum_valid,
  input  dot_types_pkg::data_word_t sum,
  input  logic                      sum_overflow,
  output dot_types_pkg::data_word_t DATA_OUT,
  output logic                      OVERFLOW,
  output logic                      DATA_OUT_ENABLE,
  output logic                      done
);
  import dot_ctrl_pkg::*;

  //////////////////////////////
  // Result FSM
  //////////////////////////////

  result_state_t state;

  // Outputs hold until the next sum
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= WAIT_SUM;
      DATA_OUT <= '0;
      OVERFLOW <= 1'b0;
    end else begin
      case (state)
        WAIT_SUM: begin
          if (sum_valid) begin
            DATA_OUT <= sum;
            OVERFLOW <= sum_overflow;
            state    <= REPORT;
          end
        end
        // Single report cycle
        REPORT: begin
          state <= WAIT_SUM;
        end
        default: begin
          state <= WAIT_SUM;
        end
      endcase
    end
  end

  // Report and completion go together
  assign DATA_OUT_ENABLE = (state == REPORT);
  assign done            = (state == REPORT);

  // A sum arriving in the report cycle would be dropped
  assert property (@(posedge CLK) disable iff (RST) DATA_OUT_ENABLE |-> !sum_valid)
    else $error("result_stage: sum arrived during the report cycle");

endmodule

// ==== logic/dot_product_top.sv ====
module dot_product_top #(
  parameter int MULT_STAGES = 2
) (
  input  logic                      CLK,
  input  logic                      RST,
  input  logic                      START,
  input  dot_types_pkg::length_t    LENGTH_IN,
  input  logic                      DATA_A_IN_ENABLE,
  input  logic                      DATA_B_IN_ENABLE,
  input  dot_types_pkg::data_word_t DATA_A_IN,
  input  dot_types_pkg::data_word_t DATA_B_IN,
  output logic                      READY,
  output logic                      DATA_OUT_ENABLE,
  output dot_types_pkg::data_word_t DATA_OUT,
  output logic                      OVERFLOW
);
  import dot_types_pkg::*;

  //////////////////////////////
  // Stage links
  //////////////////////////////

  // Decoded element pairs
  element_if  elem_bus ();

  // Accumulator to result
  logic       sum_valid;
  data_word_t sum;
  logic       sum_overflow;

  // Result back to intake
  logic       done;

  //////////////////////////////
  // Stages
  //////////////////////////////

  // Decode
  vector_intake intake_i (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .LENGTH_IN        (LENGTH_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .done             (done),
    .READY            (READY),
    .elem             (elem_bus)
  );

  // Multiply and accumulate
  dot_accumulator #(
    .MULT_STAGES (MULT_STAGES)
  ) accumulator_i (
    .CLK          (CLK),
    .RST          (RST),
    .elem         (elem_bus),
    .sum_valid    (sum_valid),
    .sum          (sum),
    .sum_overflow (sum_overflow)
  );

  // Report
  result_stage result_i (
    .CLK             (CLK),
    .RST             (RST),
    .sum_valid       (sum_valid),
    .sum             (sum),
    .sum_overflow    (sum_overflow),
    .DATA_OUT        (DATA_OUT),
    .OVERFLOW        (OVERFLOW),
    .DATA_OUT_ENABLE (DATA_OUT_ENABLE),
    .done            (done)
  );

endmodule

// ==== verification/tb_dot_product.sv ====
module tb_dot_product #(
  parameter int MULT_STAGES = 2
) ();
  timeunit 1ns;
  timeprecision 1ps;

  import dot_types_pkg::*;

  //////////////////////////////
  // Run limits
  //////////////////////////////

  // Elements over all cases with the largest random length
  localparam int TOTAL_ELEMS     = 4 + 6 * 32 + 7 + 8 + 256;
  localparam int WATCHDOG_CYCLES = 4 * TOTAL_ELEMS + 500;

  // DUT ports
  logic       CLK = 1'b0;
  logic       RST;
  logic       START;
  length_t    LENGTH_IN;
  logic       DATA_A_IN_ENABLE;
  logic       DATA_B_IN_ENABLE;
  data_word_t DATA_A_IN;
  data_word_t DATA_B_IN;
  logic       READY;
  logic       DATA_OUT_ENABLE;
  data_word_t DATA_OUT;
  logic       OVERFLOW;

  // Stimulus vectors and bookkeeping
  data_word_t  vec_a [256];
  data_word_t  vec_b [256];
  logic [31:0] lfsr_state = 32'hd6c3;
  string       cur_test;
  int          errors = 0;
  int          checks = 0;
  int          cases = 0;
  int          case_errors;
  // Last reported result that the DUT holds until the next one
  data_word_t  last_data = '0;
  logic        last_ovf = 1'b0;

  dot_product_top #(
    .MULT_STAGES (MULT_STAGES)
  ) i_dut (
    .CLK              (CLK),
    .RST              (RST),
    .START            (START),
    .LENGTH_IN        (LENGTH_IN),
    .DATA_A_IN_ENABLE (DATA_A_IN_ENABLE),
    .DATA_B_IN_ENABLE (DATA_B_IN_ENABLE),
    .DATA_A_IN        (DATA_A_IN),
    .DATA_B_IN        (DATA_B_IN),
    .READY            (READY),
    .DATA_OUT_ENABLE  (DATA_OUT_ENABLE),
    .DATA_OUT         (DATA_OUT),
    .OVERFLOW         (OVERFLOW)
  );

  always #5 CLK = ~CLK;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_step()};
    end
    return r;
  endfunction

  task automatic fill_random(input int len, input int bits);
    for (int i = 0; i < len; i++) begin
      vec_a[i] = data_word_t'(rand_bits(bits));
      vec_b[i] = data_word_t'(rand_bits(bits));
    end
  endtask

  task automatic check_word(input string what, input data_word_t exp, input data_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %b, actual %b", what, exp, act);
    end
  endtask

  task automatic open_case(input string name);
    cur_test    = name;
    case_errors = errors;
    cases++;
  endtask

  task automatic report_case();
    if (errors == case_errors) begin
      $display("%s: ok", cur_test);
    end else begin
      $display("%s: %0d error(s)", cur_test, errors - case_errors);
    end
  endtask

  // Poll READY on falling edges
  task automatic wait_ready();
    int n;
    n = 0;
    while (!READY && n < 20) begin
      @(negedge CLK);
      n++;
    end
    if (!READY) begin
      errors++;
      $display("%s: READY stayed low for %0d cycles", cur_test, n);
    end
  endtask

  //////////////////////////////
  // Vector run
  //////////////////////////////

  // Streams vec_a and vec_b, then checks the result against the model
  task automatic run_vector(input int len, input bit skewed, input bit poke);
    logic [63:0] full;
    data_word_t  exp_data;
    logic        exp_ovf;
    int          ia;
    int          ib;
    int          cyc;
    logic        want_a;
    logic        want_b;
    bit          early;
    // Full-precision model
    full = '0;
    for (int i = 0; i < len; i++) begin
      full += 64'(vec_a[i]) * 64'(vec_b[i]);
    end
    exp_data = data_word_t'(full);
    exp_ovf  = (full >= 64'h10000);
    wait_ready();
    START     = 1'b1;
    LENGTH_IN = length_t'(len);
    @(negedge CLK);
    START = 1'b0;
    check_flag({cur_test, " READY after START"}, 1'b0, READY);
    ia  = 0;
    ib  = 0;
    cyc = 0;
    while (ia < len || ib < len) begin
      want_a = (ia < len);
      want_b = (ib < len);
      if (skewed) begin
        want_a = want_a & lfsr_step();
        want_b = want_b & lfsr_step();
      end
      // A stream one ahead only moves with the other
      if (ia > ib && !want_b) begin
        want_a = 1'b0;
      end
      if (ib > ia && !want_a) begin
        want_b = 1'b0;
      end
      DATA_A_IN_ENABLE = want_a;
      DATA_B_IN_ENABLE = want_b;
      DATA_A_IN        = want_a ? vec_a[ia] : ~vec_a[ia];
      DATA_B_IN        = want_b ? vec_b[ib] : ~vec_b[ib];
      // Stray START while busy
      START = poke && (cyc == 1);
      if (START) begin
        LENGTH_IN = ~length_t'(len);
      end
      if (want_a) begin
        ia++;
      end
      if (want_b) begin
        ib++;
      end
      cyc++;
      @(negedge CLK);
    end
    // One cycle past the edge that completed the last pair
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    START            = 1'b0;
    check_word({cur_test, " DATA_OUT hold"}, last_data, DATA_OUT);
    check_flag({cur_test, " OVERFLOW hold"}, last_ovf, OVERFLOW);
    early = 1'b0;
    for (int k = 1; k <= MULT_STAGES + 3; k++) begin
      @(negedge CLK);
      // Second stray START while draining
      START = poke && (k == 1);
      if (k < MULT_STAGES + 3 && DATA_OUT_ENABLE) begin
        early = 1'b1;
      end
    end
    START = 1'b0;
    if (early) begin
      errors++;
      $display("%s: DATA_OUT_ENABLE pulsed before the expected cycle", cur_test);
    end
    if (!DATA_OUT_ENABLE) begin
      errors++;
      $display("%s: DATA_OUT_ENABLE did not pulse %0d cycles after the last pair",
               cur_test, MULT_STAGES + 3);
    end
    check_word({cur_test, " DATA_OUT"}, exp_data, DATA_OUT);
    check_flag({cur_test, " OVERFLOW"}, exp_ovf, OVERFLOW);
    check_flag({cur_test, " READY with result"}, 1'b1, READY);
    last_data = exp_data;
    last_ovf  = exp_ovf;
  endtask

  //////////////////////////////
  // Directed cases
  //////////////////////////////

  task automatic reset_values_case();
    open_case("reset_values");
    RST = 1'b1;
    repeat (8) @(posedge CLK);
    @(negedge CLK);
    check_flag({cur_test, " READY in reset"}, 1'b0, READY);
    RST = 1'b0;
    @(negedge CLK);
    check_flag({cur_test, " READY"}, 1'b1, READY);
    check_flag({cur_test, " DATA_OUT_ENABLE"}, 1'b0, DATA_OUT_ENABLE);
    check_word({cur_test, " DATA_OUT"}, '0, DATA_OUT);
    check_flag({cur_test, " OVERFLOW"}, 1'b0, OVERFLOW);
    report_case();
  endtask

  // Small operands keep the sum below 2^16
  task automatic short_vector_case();
    open_case("short_aligned");
    fill_random(4, 7);
    run_vector(4, 1'b0, 1'b0);
    report_case();
  endtask

  task automatic random_skew_case();
    int len;
    open_case("random_skew");
    for (int v = 0; v < 6; v++) begin
      len = int'(rand_bits(5)) + 1;
      fill_random(len, 16);
      run_vector(len, 1'b1, 1'b0);
    end
    report_case();
  endtask

  task automatic overflow_case();
    open_case("overflow");
    // Wide products plus carries
    vec_a[0] = 16'hffff;
    vec_b[0] = 16'hffff;
    vec_a[1] = 16'h8001;
    vec_b[1] = 16'h0002;
    vec_a[2] = 16'h00ff;
    vec_b[2] = 16'h0100;
    run_vector(3, 1'b1, 1'b0);
    // Carry out of the add only
    vec_a[0] = 16'hf000;
    vec_b[0] = 16'h0001;
    vec_a[1] = 16'h2000;
    vec_b[1] = 16'h0001;
    run_vector(2, 1'b0, 1'b0);
    // Small vector clears the flag
    vec_a[0] = 16'h0002;
    vec_b[0] = 16'h0004;
    vec_a[1] = 16'h0003;
    vec_b[1] = 16'h0005;
    run_vector(2, 1'b1, 1'b0);
    report_case();
  endtask

  task automatic back_to_back_case();
    open_case("back_to_back");
    fill_random(5, 16);
    run_vector(5, 1'b0, 1'b1);
    // Next START in the cycle READY returns
    fill_random(3, 16);
    run_vector(3, 1'b1, 1'b0);
    repeat (4) @(negedge CLK);
    check_word({cur_test, " DATA_OUT idle"}, last_data, DATA_OUT);
    check_flag({cur_test, " OVERFLOW idle"}, last_ovf, OVERFLOW);
    check_flag({cur_test, " DATA_OUT_ENABLE idle"}, 1'b0, DATA_OUT_ENABLE);
    report_case();
  endtask

  task automatic boundary_case();
    open_case("boundary_lengths");
    for (int i = 0; i < 255; i++) begin
      vec_a[i] = '1;
      vec_b[i] = '1;
    end
    run_vector(255, 1'b0, 1'b0);
    // Counter restarts after reaching 255
    fill_random(1, 16);
    run_vector(1, 1'b0, 1'b0);
    report_case();
  endtask

  //////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////

  initial begin
    RST              = 1'b1;
    START            = 1'b0;
    LENGTH_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;
    reset_values_case();
    short_vector_case();
    random_skew_case();
    overflow_case();
    back_to_back_case();
    boundary_case();
    $display("Summary: %0d cases, %0d checks, %0d errors", cases, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("test failed");
    $finish;
  end

endmodule

// ==== project.f ====
logic/dot_types_pkg.sv
logic/dot_ctrl_pkg.sv
logic/element_if.sv
logic/vector_intake.sv
logic/dot_accumulator.sv
logic/result_stage.sv
logic/dot_product_top.sv
verification/tb_dot_product.sv

// ==== Makefile ====
# Verilator build and run of the dot-product testbench

VERILATOR   ?= verilator
TOP         ?= tb_dot_product
LOG         ?= sim.log
MULT_STAGES ?= 2
BUILD_DIR   ?= obj_dir

VFLAGS = --binary --assert --top-module $(TOP) -GMULT_STAGES=$(MULT_STAGES) --Mdir $(BUILD_DIR)
BIN    = $(BUILD_DIR)/V$(TOP)

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation into $(LOG), check the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP LOG MULT_STAGES BUILD_DIR"

build:
	$(VERILATOR) $(VFLAGS) -f project.f

test: build
	./$(BIN) > $(LOG) 2>&1 || true
	@if grep -q "test failed" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "test passed" $(LOG) || { echo "FAIL: no pass line in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
